/* design/regif_pkg.sv */
`default_nettype none

package regif_pkg;

    localparam int WORD_W = 16;             // register, address and memory word width
    localparam int BYTE_W = 8;              // host data bus width
    localparam int MASK_W = 4;              // vram nibble write enables

    // host register numbers, 9..15 unused and read as zero
    typedef enum logic [3:0] {
        XR_ADDR  = 4'd0,                    // xr address, auto-increments on xr write
        XR_DATA  = 4'd1,                    // xr data
        RD_INCR  = 4'd2,                    // vram read increment
        RD_ADDR  = 4'd3,                    // vram read address
        WR_INCR  = 4'd4,                    // vram write increment
        WR_ADDR  = 4'd5,                    // vram write address
        DATA     = 4'd6,                    // vram data
        DATA_2   = 4'd7,                    // alias of DATA
        SYS_CTRL = 4'd8                     // odd byte holds write mask
    } reg_num_e;

    // one synchronized host access
    typedef struct packed {
        logic              wr;              // write strobe, one cycle
        logic              rd;              // read strobe, one cycle
        reg_num_e          reg_num;         // register addressed
        logic              bytesel;         // 0 = even (high) byte
        logic [BYTE_W-1:0] data;            // write byte from host
    } bus_evt_t;

    // memory access request from a register part
    typedef struct packed {
        logic              valid;           // one-cycle request pulse
        logic              is_xr;           // 1 = xr, 0 = vram
        logic              wr;              // 1 = write, 0 = read
        logic [MASK_W-1:0] wrmask;          // nibble enables, vram only
        logic [WORD_W-1:0] addr;
        logic [WORD_W-1:0] data;            // write data
    } mem_req_t;

    typedef enum logic [1:0] {
        IDLE,                               // no access held
        WAIT_SLOT,                          // waiting for a non-video cycle
        READ_RET                            // read word on return bus
    } acc_state_e;

    // even byte is the high byte
    function automatic logic [BYTE_W-1:0] word_byte(input logic [WORD_W-1:0] w,
                                                    input logic               sel);
        return sel ? w[BYTE_W-1:0] : w[WORD_W-1:BYTE_W];
    endfunction

endpackage

`default_nettype wire

/* design/bus_sync.sv */
`default_nettype none
`timescale 1ns/1ps

module bus_sync import regif_pkg::*; #(
    parameter int SYNC_STAGES = 2           // cs synchronizer depth
) (
    input  wire logic              clk,
    input  wire logic              reset_i,
    input  wire logic              bus_cs_n_i,      // async chip select, active low
    input  wire logic              bus_rd_nwr_i,    // 1 = read, 0 = write
    input  wire logic [3:0]        bus_reg_num_i,
    input  wire logic              bus_bytesel_i,
    input  wire logic [BYTE_W-1:0] bus_data_i,
    output      bus_evt_t          bus_evt_o
);

    logic [SYNC_STAGES-1:0] cs_sync;        // metastability chain, bit 0 first
    logic                   cs_prev;        // last synced cs for edge detect
    logic                   cs_fell;

    assign cs_fell = ~cs_sync[SYNC_STAGES-1] & cs_prev;    // high-to-low after sync

    always_ff @(posedge clk) begin
        if (reset_i) begin
            cs_sync   <= '1;                // bus idle
            cs_prev   <= 1'b1;
            bus_evt_o <= '0;
        end else begin
            cs_sync <= SYNC_STAGES'({cs_sync, bus_cs_n_i});
            cs_prev <= cs_sync[SYNC_STAGES-1];

            bus_evt_o.wr <= cs_fell & ~bus_rd_nwr_i;   // strobes last one cycle
            bus_evt_o.rd <= cs_fell & bus_rd_nwr_i;
            if (cs_fell) begin
                // other bus lines settled long before synced cs
                bus_evt_o.reg_num <= reg_num_e'(bus_reg_num_i);
                bus_evt_o.bytesel <= bus_bytesel_i;
                bus_evt_o.data    <= bus_data_i;
            end
        end
    end

endmodule

`default_nettype wire

/* design/vram_regs.sv */
`default_nettype none
`timescale 1ns/1ps

module vram_regs import regif_pkg::*; (
    input  wire logic              clk,
    input  wire logic              reset_i,
    input  wire bus_evt_t          bus_evt_i,
    input  wire logic              done_i,          // our access took its slot
    input  wire logic              rdata_valid_i,   // read word on rdata_i
    input  wire logic [WORD_W-1:0] rdata_i,
    output      mem_req_t          req_o,
    output      logic [BYTE_W-1:0] rd_byte_o
);

    logic [WORD_W-1:0] rd_incr;             // RD_INCR
    logic [WORD_W-1:0] rd_addr;             // RD_ADDR, next prefetch address
    logic [WORD_W-1:0] wr_incr;             // WR_INCR
    logic [WORD_W-1:0] wr_addr;             // WR_ADDR
    logic [BYTE_W-1:0] data_even;           // even byte of DATA held until odd byte
    logic [WORD_W-1:0] rd_data;             // last prefetched word
    logic [MASK_W-1:0] wrmask;              // nibble mask from SYS_CTRL
    logic              even_wr;
    logic              odd_wr;
    logic              odd_rd;
    logic [BYTE_W-1:0] d;

    assign even_wr = bus_evt_i.wr & ~bus_evt_i.bytesel;
    assign odd_wr  = bus_evt_i.wr & bus_evt_i.bytesel;  // odd byte completes the access
    assign odd_rd  = bus_evt_i.rd & bus_evt_i.bytesel;
    assign d       = bus_evt_i.data;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            rd_incr   <= '0;
            rd_addr   <= '0;
            wr_incr   <= '0;
            wr_addr   <= '0;
            data_even <= '0;
            rd_data   <= '0;
            wrmask    <= '1;                // all nibbles enabled
            req_o     <= '0;
        end else begin
            req_o.valid <= 1'b0;            // request is a single pulse

            if (done_i) begin
                if (req_o.wr) begin
                    wr_addr <= wr_addr + wr_incr;   // wraps mod 2^16
                end else begin
                    rd_addr <= rd_addr + rd_incr;   // advance past word just read
                end
            end
            if (rdata_valid_i) begin
                rd_data <= rdata_i;
            end

            if (even_wr) begin
                case (bus_evt_i.reg_num)
                    RD_INCR:      rd_incr[WORD_W-1:BYTE_W] <= d;
                    RD_ADDR:      rd_addr[WORD_W-1:BYTE_W] <= d;
                    WR_INCR:      wr_incr[WORD_W-1:BYTE_W] <= d;
                    WR_ADDR:      wr_addr[WORD_W-1:BYTE_W] <= d;
                    DATA, DATA_2: data_even <= d;
                    default:      ;                 // SYS_CTRL even byte has no bits
                endcase
            end

            if (odd_wr) begin
                case (bus_evt_i.reg_num)
                    RD_INCR: rd_incr[BYTE_W-1:0] <= d;
                    RD_ADDR: begin
                        rd_addr[BYTE_W-1:0] <= d;
                        req_o <= '{valid: 1'b1, is_xr: 1'b0, wr: 1'b0, wrmask: wrmask,
                                   addr: {rd_addr[WORD_W-1:BYTE_W], d}, data: '0};
                    end
                    WR_INCR: wr_incr[BYTE_W-1:0] <= d;
                    WR_ADDR: wr_addr[BYTE_W-1:0] <= d;
                    DATA, DATA_2: begin
                        req_o <= '{valid: 1'b1, is_xr: 1'b0, wr: 1'b1, wrmask: wrmask,
                                   addr: wr_addr, data: {data_even, d}};
                    end
                    SYS_CTRL: wrmask <= d[MASK_W-1:0];
                    default:  ;
                endcase
            end

            // odd-byte data read fetches the next word
            if (odd_rd && (bus_evt_i.reg_num == DATA || bus_evt_i.reg_num == DATA_2)) begin
                req_o <= '{valid: 1'b1, is_xr: 1'b0, wr: 1'b0, wrmask: wrmask,
                           addr: rd_addr, data: '0};
            end
        end
    end

    // byte for the register the host currently addresses
    always_comb begin
        case (bus_evt_i.reg_num)
            RD_INCR:      rd_byte_o = word_byte(rd_incr, bus_evt_i.bytesel);
            RD_ADDR:      rd_byte_o = word_byte(rd_addr, bus_evt_i.bytesel);
            WR_INCR:      rd_byte_o = word_byte(wr_incr, bus_evt_i.bytesel);
            WR_ADDR:      rd_byte_o = word_byte(wr_addr, bus_evt_i.bytesel);
            DATA, DATA_2: rd_byte_o = word_byte(rd_data, bus_evt_i.bytesel);
            SYS_CTRL:     rd_byte_o = bus_evt_i.bytesel ? BYTE_W'(wrmask) : '0;
            default:      rd_byte_o = '0;   // xr or unused
        endcase
    end

endmodule

`default_nettype wire

/* design/xr_regs.sv */
`default_nettype none
`timescale 1ns/1ps

module xr_regs import regif_pkg::*; (
    input  wire logic              clk,
    input  wire logic              reset_i,
    input  wire bus_evt_t          bus_evt_i,
    input  wire logic              done_i,
    input  wire logic              rdata_valid_i,
    input  wire logic [WORD_W-1:0] rdata_i,
    output      mem_req_t          req_o,
    output      logic [BYTE_W-1:0] rd_byte_o
);

    logic [WORD_W-1:0] xr_addr;             // XR_ADDR
    logic [BYTE_W-1:0] data_even;           // even byte of XR_DATA
    logic [WORD_W-1:0] rd_data;             // last xr word read
    logic [BYTE_W-1:0] d;

    assign d = bus_evt_i.data;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            xr_addr   <= '0;
            data_even <= '0;
            rd_data   <= '0;
            req_o     <= '0;
        end else begin
            req_o.valid <= 1'b0;

            if (done_i && req_o.wr) begin
                xr_addr <= xr_addr + 1'b1;  // step after each xr write
            end
            if (rdata_valid_i) begin
                rd_data <= rdata_i;
            end

            if (bus_evt_i.wr && !bus_evt_i.bytesel) begin
                case (bus_evt_i.reg_num)
                    XR_ADDR: xr_addr[WORD_W-1:BYTE_W] <= d;
                    XR_DATA: data_even <= d;
                    default: ;
                endcase
            end

            if (bus_evt_i.wr && bus_evt_i.bytesel) begin
                case (bus_evt_i.reg_num)
                    XR_ADDR: begin
                        xr_addr[BYTE_W-1:0] <= d;
                        // new address reads its word into XR_DATA
                        req_o <= '{valid: 1'b1, is_xr: 1'b1, wr: 1'b0, wrmask: '1,
                                   addr: {xr_addr[WORD_W-1:BYTE_W], d}, data: '0};
                    end
                    XR_DATA: begin
                        req_o <= '{valid: 1'b1, is_xr: 1'b1, wr: 1'b1, wrmask: '1,
                                   addr: xr_addr, data: {data_even, d}};
                    end
                    default: ;
                endcase
            end
        end
    end

    always_comb begin
        case (bus_evt_i.reg_num)
            XR_ADDR: rd_byte_o = word_byte(xr_addr, bus_evt_i.bytesel);
            XR_DATA: rd_byte_o = word_byte(rd_data, bus_evt_i.bytesel);
            default: rd_byte_o = '0;        // not an xr register
        endcase
    end

endmodule

`default_nettype wire

/* design/access_combiner.sv */
`default_nettype none
`timescale 1ns/1ps

module access_combiner import regif_pkg::*; (
    input  wire logic              clk,
    input  wire logic              reset_i,
    input  wire mem_req_t          vram_req_i,
    input  wire mem_req_t          xr_req_i,
    input  wire logic [BYTE_W-1:0] vram_byte_i,
    input  wire logic [BYTE_W-1:0] xr_byte_i,
    input  wire logic              vgen_sel_i,      // video owns this cycle
    input  wire logic [WORD_W-1:0] regs_data_i,     // vram read data
    input  wire logic [WORD_W-1:0] xr_data_i,       // xr read data
    output      logic              vram_done_o,
    output      logic              xr_done_o,
    output      logic              vram_rdata_valid_o,
    output      logic              xr_rdata_valid_o,
    output      logic [WORD_W-1:0] rdata_o,
    output      logic [BYTE_W-1:0] bus_data_o,
    output      logic              regs_vram_sel_o,
    output      logic              regs_xr_sel_o,
    output      logic              regs_wr_o,
    output      logic [MASK_W-1:0] regs_wrmask_o,
    output      logic [WORD_W-1:0] regs_addr_o,
    output      logic [WORD_W-1:0] regs_data_o
);

    acc_state_e state;
    mem_req_t   req;                        // access being served
    logic       waiting;
    logic       slot_free;                  // access happens this cycle
    logic       ret;

    assign waiting   = (state == WAIT_SLOT);
    assign slot_free = waiting & ~vgen_sel_i;
    assign ret       = (state == READ_RET);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state      <= IDLE;
            req        <= '0;
            req.wrmask <= '1;
        end else begin
            case (state)
                IDLE: begin
                    if (vram_req_i.valid) begin     // vram first if both arrive
                        req   <= vram_req_i;
                        state <= WAIT_SLOT;
                    end else if (xr_req_i.valid) begin
                        req   <= xr_req_i;
                        state <= WAIT_SLOT;
                    end
                end
                WAIT_SLOT: if (!vgen_sel_i) state <= req.wr ? IDLE : READ_RET;
                READ_RET:  state <= IDLE;   // word captured by owner now
                default:   state <= IDLE;
            endcase
        end
    end

    // memory side, held steady while video has the slot
    assign regs_vram_sel_o = waiting & ~req.is_xr;
    assign regs_xr_sel_o   = waiting & req.is_xr;
    assign regs_wr_o       = waiting & req.wr;
    assign regs_wrmask_o   = req.wrmask;
    assign regs_addr_o     = req.addr;
    assign regs_data_o     = req.data;

    // completion back to the owner
    assign vram_done_o        = slot_free & ~req.is_xr;
    assign xr_done_o          = slot_free & req.is_xr;
    assign vram_rdata_valid_o = ret & ~req.is_xr;
    assign xr_rdata_valid_o   = ret & req.is_xr;
    assign rdata_o            = req.is_xr ? xr_data_i : regs_data_i;

    assign bus_data_o = vram_byte_i | xr_byte_i;    // non-owner drives zero

endmodule

`default_nettype wire

/* design/reg_interface_top.sv */
`default_nettype none
`timescale 1ns/1ps

module reg_interface_top import regif_pkg::*; #(
    parameter int SYNC_STAGES = 2
) (
    input  wire logic              clk,
    input  wire logic              reset_i,
    input  wire logic              bus_cs_n_i,
    input  wire logic              bus_rd_nwr_i,
    input  wire logic [3:0]        bus_reg_num_i,
    input  wire logic              bus_bytesel_i,
    input  wire logic [BYTE_W-1:0] bus_data_i,
    output      logic [BYTE_W-1:0] bus_data_o,
    input  wire logic              vgen_sel_i,
    input  wire logic [WORD_W-1:0] regs_data_i,
    input  wire logic [WORD_W-1:0] xr_data_i,
    output      logic              regs_vram_sel_o,
    output      logic              regs_xr_sel_o,
    output      logic              regs_wr_o,
    output      logic [MASK_W-1:0] regs_wrmask_o,
    output      logic [WORD_W-1:0] regs_addr_o,
    output      logic [WORD_W-1:0] regs_data_o
);

    bus_evt_t          bus_evt;
    mem_req_t          vram_req;
    mem_req_t          xr_req;
    logic [BYTE_W-1:0] vram_byte;
    logic [BYTE_W-1:0] xr_byte;
    logic              vram_done;
    logic              xr_done;
    logic              vram_rdata_valid;
    logic              xr_rdata_valid;
    logic [WORD_W-1:0] rdata;               // shared return word

    bus_sync #(.SYNC_STAGES(SYNC_STAGES)) u_bus_sync (
        .clk(clk), .reset_i(reset_i),
        .bus_cs_n_i(bus_cs_n_i), .bus_rd_nwr_i(bus_rd_nwr_i),
        .bus_reg_num_i(bus_reg_num_i), .bus_bytesel_i(bus_bytesel_i),
        .bus_data_i(bus_data_i), .bus_evt_o(bus_evt)
    );

    vram_regs u_vram_regs (
        .clk(clk), .reset_i(reset_i), .bus_evt_i(bus_evt),
        .done_i(vram_done), .rdata_valid_i(vram_rdata_valid), .rdata_i(rdata),
        .req_o(vram_req), .rd_byte_o(vram_byte)
    );

    xr_regs u_xr_regs (
        .clk(clk), .reset_i(reset_i), .bus_evt_i(bus_evt),
        .done_i(xr_done), .rdata_valid_i(xr_rdata_valid), .rdata_i(rdata),
        .req_o(xr_req), .rd_byte_o(xr_byte)
    );

    access_combiner u_access_combiner (
        .clk(clk), .reset_i(reset_i),
        .vram_req_i(vram_req), .xr_req_i(xr_req),
        .vram_byte_i(vram_byte), .xr_byte_i(xr_byte),
        .vgen_sel_i(vgen_sel_i), .regs_data_i(regs_data_i), .xr_data_i(xr_data_i),
        .vram_done_o(vram_done), .xr_done_o(xr_done),
        .vram_rdata_valid_o(vram_rdata_valid), .xr_rdata_valid_o(xr_rdata_valid),
        .rdata_o(rdata), .bus_data_o(bus_data_o),
        .regs_vram_sel_o(regs_vram_sel_o), .regs_xr_sel_o(regs_xr_sel_o),
        .regs_wr_o(regs_wr_o), .regs_wrmask_o(regs_wrmask_o),
        .regs_addr_o(regs_addr_o), .regs_data_o(regs_data_o)
    );

endmodule

`default_nettype wire

/* tb/tb_clock_gen.sv */
`default_nettype none
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS = 20            // full clock period
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;                       // first rising edge half a period in
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

endmodule

`default_nettype wire

/* tb/reg_interface_tb.sv */
`default_nettype none
`timescale 1ns/1ps

module reg_interface_tb import regif_pkg::*; ();

    localparam int SYNC_STAGES    = 2;
    localparam int GAP_CYCLES     = 8;      // idle cycles between host accesses
    localparam int ACCESS_TIMEOUT = 40;     // cycles allowed for one memory access
    localparam logic [31:0] SEED  = 32'hcdb6_326f;

    logic              clk;
    logic              reset_i;
    logic              bus_cs_n_i;
    logic              bus_rd_nwr_i;
    logic [3:0]        bus_reg_num_i;
    logic              bus_bytesel_i;
    logic [BYTE_W-1:0] bus_data_i;
    logic [BYTE_W-1:0] bus_data_o;
    logic              vgen_sel_i;
    logic [WORD_W-1:0] regs_data_i;
    logic [WORD_W-1:0] xr_data_i;
    logic              regs_vram_sel_o;
    logic              regs_xr_sel_o;
    logic              regs_wr_o;
    logic [MASK_W-1:0] regs_wrmask_o;
    logic [WORD_W-1:0] regs_addr_o;
    logic [WORD_W-1:0] regs_data_o;

    logic [WORD_W-1:0] vram_mem [0:65535];  // vram model
    logic [WORD_W-1:0] xr_mem [0:255];      // xr model
    logic [WORD_W-1:0] vram_ret;
    logic [WORD_W-1:0] xr_ret;
    logic              mem_hit;
    logic              mem_rd;
    int                access_count;        // completed memory accesses

    // shadow copy of the register contents
    logic [WORD_W-1:0] sh_xr_addr;
    logic [WORD_W-1:0] sh_xr_rd;
    logic [WORD_W-1:0] sh_rd_incr;
    logic [WORD_W-1:0] sh_rd_addr;
    logic [WORD_W-1:0] sh_wr_incr;
    logic [WORD_W-1:0] sh_wr_addr;
    logic [WORD_W-1:0] sh_rd_data;
    logic [MASK_W-1:0] sh_mask;

    logic [31:0]       vgen_rng;
    logic [31:0]       data_rng;
    logic              vgen_rand_en;
    int                vgen_run;            // consecutive video cycles
    logic [15:0]       exp_q [$];
    logic [15:0]       act_q [$];
    string             name_q [$];
    int                test_checks;
    int                test_errors;
    int                total_checks;
    int                total_errors;
    int                tests_run;

    tb_clock_gen #(.PERIOD_NS(20)) u_clock_gen (.clk_o(clk));

    reg_interface_top #(.SYNC_STAGES(SYNC_STAGES)) UUT (
        .clk(clk), .reset_i(reset_i),
        .bus_cs_n_i(bus_cs_n_i), .bus_rd_nwr_i(bus_rd_nwr_i),
        .bus_reg_num_i(bus_reg_num_i), .bus_bytesel_i(bus_bytesel_i),
        .bus_data_i(bus_data_i), .bus_data_o(bus_data_o),
        .vgen_sel_i(vgen_sel_i), .regs_data_i(regs_data_i), .xr_data_i(xr_data_i),
        .regs_vram_sel_o(regs_vram_sel_o), .regs_xr_sel_o(regs_xr_sel_o),
        .regs_wr_o(regs_wr_o), .regs_wrmask_o(regs_wrmask_o),
        .regs_addr_o(regs_addr_o), .regs_data_o(regs_data_o)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] x);
        return x * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [WORD_W-1:0] merge_nibbles(input logic [WORD_W-1:0] old_w,
                                                        input logic [WORD_W-1:0] new_w,
                                                        input logic [MASK_W-1:0] m);
        logic [WORD_W-1:0] w;
        w = old_w;
        for (int i = 0; i < MASK_W; i++) begin
            if (m[i]) w[4*i +: 4] = new_w[4*i +: 4];    // enabled nibble only
        end
        return w;
    endfunction

    // expected byte the host sees for a register and byte select
    function automatic logic [BYTE_W-1:0] expected_byte(input logic [3:0] num, input logic sel);
        logic [WORD_W-1:0] w;
        case (num)
            XR_ADDR:      w = sh_xr_addr;
            XR_DATA:      w = sh_xr_rd;
            RD_INCR:      w = sh_rd_incr;
            RD_ADDR:      w = sh_rd_addr;
            WR_INCR:      w = sh_wr_incr;
            WR_ADDR:      w = sh_wr_addr;
            DATA, DATA_2: w = sh_rd_data;
            SYS_CTRL:     w = {12'h000, sh_mask};   // even byte always zero
            default:      w = '0;
        endcase
        return sel ? w[7:0] : w[15:8];              // even byte is the high one
    endfunction

    // memory models see an access cycle as select high with video idle
    always @(posedge clk) begin
        mem_hit = (regs_vram_sel_o | regs_xr_sel_o) & ~vgen_sel_i;
        mem_rd  = mem_hit & ~regs_wr_o;
        if (mem_hit) begin
            access_count++;
            if (regs_vram_sel_o && regs_wr_o) begin
                vram_mem[regs_addr_o] = merge_nibbles(vram_mem[regs_addr_o], regs_data_o,
                                                      regs_wrmask_o);
            end else if (regs_xr_sel_o && regs_wr_o) begin
                xr_mem[regs_addr_o[7:0]] = regs_data_o;     // 256 words so upper bits ignored
            end
            vram_ret = regs_vram_sel_o ? vram_mem[regs_addr_o] : '0;   // selected memory only
            xr_ret   = regs_xr_sel_o ? xr_mem[regs_addr_o[7:0]] : '0;
        end
        #2;
        regs_data_i = mem_rd ? vram_ret : '0;   // word valid for one cycle
        xr_data_i   = mem_rd ? xr_ret : '0;
    end

    // video owns random slots but never more than 3 in a row
    always @(posedge clk) begin
        #2;
        if (vgen_rand_en) begin
            vgen_rng   = lcg_next(vgen_rng);
            vgen_sel_i = vgen_rng[31] && (vgen_run < 3);
            vgen_run   = vgen_sel_i ? vgen_run + 1 : 0;
        end else begin
            vgen_sel_i = 1'b0;
            vgen_run   = 0;
        end
    end

    task automatic check_value(input string name, input logic [15:0] exp,
                               input logic [15:0] act);
        test_checks++;
        if (act !== exp) begin
            test_errors++;
            $display("error: %s expected %h actual %h", name, exp, act);
        end
    endtask

    // compare process drains pending results every edge
    always @(posedge clk) begin
        while (exp_q.size() > 0) begin
            check_value(name_q.pop_front(), exp_q.pop_front(), act_q.pop_front());
        end
    end

    task automatic expect_value(input string name, input logic [15:0] exp,
                                input logic [15:0] act);
        name_q.push_back(name);
        exp_q.push_back(exp);
        act_q.push_back(act);
    endtask

    task automatic idle(input int n);
        repeat (n) @(posedge clk);
        #2;
    endtask

    // one host byte access with cs held low SYNC_STAGES+2 cycles
    task automatic bus_cycle(input logic rd, input logic [3:0] num, input logic sel,
                             input logic [7:0] wdata, output logic [7:0] rdata);
        @(posedge clk);
        #2;
        bus_rd_nwr_i  = rd;
        bus_reg_num_i = num;
        bus_bytesel_i = sel;
        bus_data_i    = wdata;
        bus_cs_n_i    = 1'b0;
        repeat (SYNC_STAGES + 2) @(posedge clk);
        #2;
        rdata      = bus_data_o;            // event is one cycle old here
        bus_cs_n_i = 1'b1;
    endtask

    task automatic wait_access(input string what);
        int start;
        int n;
        start = access_count;
        n     = 0;
        while (access_count == start && n < ACCESS_TIMEOUT) begin
            @(posedge clk);
            #2;
            n++;
        end
        if (access_count == start) begin
            test_errors++;
            $display("timeout: no memory access for %s within %0d cycles", what, n);
        end
    endtask

    task automatic write_reg(input logic [3:0] num, input logic [WORD_W-1:0] w);
        logic [7:0] ignored;
        bus_cycle(1'b0, num, 1'b0, w[15:8], ignored);
        idle(GAP_CYCLES);
        bus_cycle(1'b0, num, 1'b1, w[7:0], ignored);
        if (num inside {XR_ADDR, XR_DATA, RD_ADDR, DATA, DATA_2}) begin
            wait_access($sformatf("write of reg %0d", num));
        end
        idle(GAP_CYCLES);
        case (num)
            XR_ADDR: begin
                sh_xr_addr = w;
                sh_xr_rd   = xr_mem[w[7:0]];    // read on new address
            end
            XR_DATA:  sh_xr_addr = sh_xr_addr + 16'd1;
            RD_INCR:  sh_rd_incr = w;
            RD_ADDR: begin
                sh_rd_data = vram_mem[w];
                sh_rd_addr = w + sh_rd_incr;    // prefetch steps the address
            end
            WR_INCR:      sh_wr_incr = w;
            WR_ADDR:      sh_wr_addr = w;
            DATA, DATA_2: sh_wr_addr = sh_wr_addr + sh_wr_incr;
            SYS_CTRL:     sh_mask = w[3:0];
            default: ;
        endcase
    endtask

    task automatic read_reg(input string name, input logic [3:0] num);
        logic [7:0] b;
        for (int s = 0; s < 2; s++) begin
            bus_cycle(1'b1, num, s[0], 8'h00, b);
            expect_value($sformatf("%s reg %0d byte %0d", name, num, s),
                         {8'h00, expected_byte(num, s[0])}, {8'h00, b});
            if (s == 1 && (num == DATA || num == DATA_2)) begin
                wait_access(name);          // odd byte read prefetches next word
                sh_rd_data = vram_mem[sh_rd_addr];
                sh_rd_addr = sh_rd_addr + sh_rd_incr;
            end
            idle(GAP_CYCLES);
        end
    endtask

    task automatic vram_write_test(input string name, input logic [15:0] start,
                                   input logic [15:0] incr, input int n);
        logic [15:0] a;
        logic [15:0] w;
        logic [15:0] exp;
        write_reg(WR_INCR, incr);
        write_reg(WR_ADDR, start);
        for (int k = 0; k < n; k++) begin
            data_rng = lcg_next(data_rng);
            w        = data_rng[31:16];
            a        = sh_wr_addr;
            exp      = merge_nibbles(vram_mem[a], w, sh_mask);
            write_reg((k % 2) ? DATA_2 : DATA, w);      // both aliases
            expect_value($sformatf("%s word %0d", name, k), exp, vram_mem[a]);
        end
        read_reg(name, WR_ADDR);            // start plus n*incr with wrap
    endtask

    task automatic vram_read_test(input string name, input logic [15:0] start,
                                  input logic [15:0] incr, input int n);
        write_reg(RD_INCR, incr);
        write_reg(RD_ADDR, start);
        for (int k = 0; k < 2 * n; k++) begin
            read_reg(name, (k < n) ? DATA : DATA_2);
        end
    endtask

    task automatic finish_test(input string name);
        idle(1);                            // let the compare process catch up
        $display("test %s: %0d checks, %0d errors", name, test_checks, test_errors);
        total_checks += test_checks;
        total_errors += test_errors;
        tests_run++;
        test_checks = 0;
        test_errors = 0;
    endtask

    initial begin
        reset_i       = 1'b1;
        bus_cs_n_i    = 1'b1;
        bus_rd_nwr_i  = 1'b0;
        bus_reg_num_i = 4'h0;
        bus_bytesel_i = 1'b0;
        bus_data_i    = '0;
        vgen_sel_i    = 1'b0;
        regs_data_i   = '0;
        xr_data_i     = '0;
        vgen_rand_en  = 1'b0;
        vgen_run      = 0;
        vgen_rng      = SEED;
        data_rng      = SEED;
        access_count  = 0;
        test_checks   = 0;
        test_errors   = 0;
        total_checks  = 0;
        total_errors  = 0;
        tests_run     = 0;
        {sh_xr_addr, sh_xr_rd, sh_rd_incr, sh_rd_addr} = '0;
        {sh_wr_incr, sh_wr_addr, sh_rd_data} = '0;
        sh_mask = 4'hf;                     // reset mask enables all nibbles
        for (int a = 0; a < 65536; a++) vram_mem[a] = {a[7:0], a[15:8]} ^ 16'h3c5a;
        for (int a = 0; a < 256; a++) xr_mem[a] = 16'(a * 257) ^ 16'h0f0f;

        repeat (2) @(posedge clk);
        #2;
        reset_i = 1'b0;
        idle(4);

        write_reg(RD_INCR, 16'h00a5);
        write_reg(WR_INCR, 16'h1234);
        write_reg(WR_ADDR, 16'hbeef);
        read_reg("readback", RD_INCR);
        read_reg("readback", WR_INCR);
        read_reg("readback", WR_ADDR);
        for (int r = 9; r < 16; r++) read_reg("readback", 4'(r));   // unused numbers
        finish_test("readback");

        vram_write_test("vram_write", 16'hfff8, 16'h0003, 6);       // wraps past ffff
        finish_test("vram_write");

        vram_read_test("vram_read", 16'h0100, 16'h0002, 3);
        finish_test("vram_read");

        write_reg(SYS_CTRL, 16'h0005);
        read_reg("write_mask", SYS_CTRL);
        vram_write_test("write_mask", 16'h0200, 16'h0001, 4);
        write_reg(SYS_CTRL, 16'h000f);
        finish_test("write_mask");

        write_reg(XR_ADDR, 16'h0010);
        for (int k = 0; k < 3; k++) begin
            data_rng = lcg_next(data_rng);
            write_reg(XR_DATA, data_rng[31:16]);
            expect_value($sformatf("xr word %0d", k), data_rng[31:16], xr_mem[8'h10 + k]);
        end
        read_reg("xr", XR_ADDR);            // advanced once per write
        write_reg(XR_ADDR, 16'h0011);
        read_reg("xr", XR_DATA);
        finish_test("xr");

        vgen_rand_en = 1'b1;
        vram_write_test("backpressure", 16'hfff8, 16'h0003, 6);
        vram_read_test("backpressure", 16'h0100, 16'h0002, 3);
        vgen_rand_en = 1'b0;
        finish_test("backpressure");

        $display("%0d tests, %0d checks, %0d errors", tests_run, total_checks, total_errors);
        if (total_errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
design/regif_pkg.sv
design/bus_sync.sv
design/vram_regs.sv
design/xr_regs.sv
design/access_combiner.sv
design/reg_interface_top.sv
tb/tb_clock_gen.sv
tb/reg_interface_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = reg_interface_tb
FILELIST  = sim.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
